// ==== Bender.yml ====
package:
  name: rv_exec

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/rv_exec_pkg.sv
      - hdl/rv_idu.sv
      - hdl/rv_regfile.sv
      - hdl/rv_exu.sv
      - hdl/rv_exec_top.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - tb/rv_exec_top_tb.sv

// ==== hdl/rv_exec_consts.svh ====
`ifndef RV_EXEC_CONSTS_SVH
`define RV_EXEC_CONSTS_SVH

// ------------------------------------------------------------
// Datapath sizing
// ------------------------------------------------------------

// Width of a register and of the ALU datapath
`define RV_XLEN 32

// Architectural integer registers, x0 included
`define RV_NUM_REGS 32

// Bits needed to index one register
`define RV_REG_AW 5

// ------------------------------------------------------------
// Fixed encodings
// ------------------------------------------------------------

// Full ebreak word, no other SYSTEM encoding is taken
`define RV_EBREAK_WORD 32'h0010_0073

`endif

// ==== hdl/rv_exec_pkg.sv ====
`include "rv_exec_consts.svh"

package rv_exec_pkg;

    // ------------------------------------------------------------
    // Instruction field encodings
    // ------------------------------------------------------------

    // Major opcode, bits 6:0 of the instruction
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,
        OPC_SYSTEM = 7'b1110011
    } rv_opcode_e;

    // OP-IMM function, bits 14:12
    // Shift right shares one code, bit 30 picks the flavour
    typedef enum logic [2:0] {
        F3_ADDI      = 3'b000,
        F3_SLLI      = 3'b001,
        F3_SLTI      = 3'b010,
        F3_SLTIU     = 3'b011,
        F3_XORI      = 3'b100,
        F3_SRLI_SRAI = 3'b101,
        F3_ORI       = 3'b110,
        F3_ANDI      = 3'b111
    } rv_funct3_e;

    // ------------------------------------------------------------
    // Internal operation code
    // ------------------------------------------------------------

    // What the execute unit does with operand and immediate
    typedef enum logic [3:0] {
        ALU_ADD     = 4'd0,
        ALU_SLT     = 4'd1,
        ALU_SLTU    = 4'd2,
        ALU_XOR     = 4'd3,
        ALU_OR      = 4'd4,
        ALU_AND     = 4'd5,
        ALU_SLL     = 4'd6,
        ALU_SRL     = 4'd7,
        ALU_SRA     = 4'd8,
        ALU_EBREAK  = 4'd9,
        ALU_ILLEGAL = 4'd10
    } rv_alu_op_e;

    // ------------------------------------------------------------
    // Bundles between blocks
    // ------------------------------------------------------------

    // Decoder output
    typedef struct packed {
        rv_alu_op_e                 alu_op;
        logic [`RV_REG_AW-1:0]      rd;
        // Already sign-extended
        logic [`RV_XLEN-1:0]        imm;
        // Cleared for rd == x0
        logic                       rd_write;
    } rv_decoded_t;

    // Contents of the issue register
    typedef struct packed {
        rv_decoded_t                decoded;
        logic [`RV_XLEN-1:0]        rs1_value;
    } rv_issue_t;

    // Commit port and writeback
    typedef struct packed {
        logic [`RV_REG_AW-1:0]      rd;
        logic [`RV_XLEN-1:0]        value;
        logic                       wen;
        logic                       halt;
        logic                       illegal;
    } rv_commit_t;

endpackage

// ==== hdl/rv_exec_top.sv ====
`include "rv_exec_consts.svh"

module rv_exec_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_valid,
    output logic                    instr_ready,
    input  logic [`RV_XLEN-1:0]     instr,
    output logic                    commit_valid,
    input  logic                    commit_ready,
    output rv_exec_pkg::rv_commit_t commit,
    output logic                    halted
);

    // ------------------------------------------------------------
    // Decode and operand read, side by side
    // ------------------------------------------------------------

    rv_exec_pkg::rv_decoded_t decoded;
    rv_exec_pkg::rv_issue_t   issue_d;
    rv_exec_pkg::rv_issue_t   issue_q;
    rv_exec_pkg::rv_commit_t  result;
    logic [`RV_XLEN-1:0]      rs1_data;
    logic                     issue_valid_q;
    logic                     halted_q;
    logic                     intake_fire;
    logic                     commit_fire;
    logic                     wb_en;

    rv_idu u_idu (
        .instr   (instr),
        .decoded (decoded)
    );

    rv_regfile u_regfile (
        .clk      (clk),
        .rst      (rst),
        // rs1 field
        .rs1_addr (instr[19:15]),
        .rs1_data (rs1_data),
        .wr_en    (wb_en),
        .wr_addr  (result.rd),
        .wr_data  (result.value)
    );

    assign issue_d.decoded   = decoded;
    assign issue_d.rs1_value = rs1_data;

    // ------------------------------------------------------------
    // Handshakes
    // ------------------------------------------------------------

    assign commit_fire = issue_valid_q && commit_ready;

    // Free slot or slot draining now, nothing after an ebreak
    assign instr_ready = !halted_q && (!issue_valid_q || (commit_fire && !result.halt));

    assign intake_fire = instr_valid && instr_ready;

    // ------------------------------------------------------------
    // Issue register and halt flag
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid_q <= 1'b0;
            halted_q      <= 1'b0;
        end else begin
            if (intake_fire) begin
                issue_valid_q <= 1'b1;
            end else if (commit_fire) begin
                issue_valid_q <= 1'b0;
            end
            // Sticky once ebreak commits
            if (commit_fire && result.halt) begin
                halted_q <= 1'b1;
            end
        end
    end

    // Payload only
    always_ff @(posedge clk) begin
        if (intake_fire) begin
            issue_q <= issue_d;
        end
    end

    // ------------------------------------------------------------
    // Execute, commit and writeback
    // ------------------------------------------------------------

    rv_exu u_exu (
        .issue  (issue_q),
        .result (result)
    );

    assign commit_valid = issue_valid_q;
    assign commit       = result;
    assign halted       = halted_q;

    // Write lands at the commit edge
    assign wb_en = commit_fire && result.wen;

endmodule

// ==== hdl/rv_exu.sv ====
`include "rv_exec_consts.svh"

module rv_exu (
    input  rv_exec_pkg::rv_issue_t  issue,
    output rv_exec_pkg::rv_commit_t result
);

    // ------------------------------------------------------------
    // Operands
    // ------------------------------------------------------------

    logic [`RV_XLEN-1:0]     op_a;
    logic [`RV_XLEN-1:0]     op_b;
    logic [4:0]              shamt;
    rv_exec_pkg::rv_alu_op_e alu_op;
    logic [`RV_XLEN-1:0]     alu_out;
    logic                    is_halt;
    logic                    is_illegal;

    assign op_a   = issue.rs1_value;
    assign op_b   = issue.decoded.imm;
    assign alu_op = issue.decoded.alu_op;

    // Shift amount, low five immediate bits
    assign shamt = op_b[4:0];

    // ------------------------------------------------------------
    // ALU
    // ------------------------------------------------------------

    always_comb begin
        alu_out = '0;
        case (alu_op)
            rv_exec_pkg::ALU_ADD: begin
                alu_out = op_a + op_b;
            end
            rv_exec_pkg::ALU_SLT: begin
                // Signed compare, result 1 or 0
                alu_out = {{(`RV_XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            end
            rv_exec_pkg::ALU_SLTU: begin
                alu_out = {{(`RV_XLEN-1){1'b0}}, (op_a < op_b)};
            end
            rv_exec_pkg::ALU_XOR: alu_out = op_a ^ op_b;
            rv_exec_pkg::ALU_OR:  alu_out = op_a | op_b;
            rv_exec_pkg::ALU_AND: alu_out = op_a & op_b;
            rv_exec_pkg::ALU_SLL: alu_out = op_a << shamt;
            rv_exec_pkg::ALU_SRL: alu_out = op_a >> shamt;
            rv_exec_pkg::ALU_SRA: begin
                // Sign fill from bit 31
                alu_out = $unsigned($signed(op_a) >>> shamt);
            end
            default: begin
                // ebreak and illegal produce no value
                alu_out = '0;
            end
        endcase
    end

    // ------------------------------------------------------------
    // Commit flags
    // ------------------------------------------------------------

    assign is_halt    = (alu_op == rv_exec_pkg::ALU_EBREAK);
    assign is_illegal = (alu_op == rv_exec_pkg::ALU_ILLEGAL);

    assign result.rd      = issue.decoded.rd;
    assign result.value   = alu_out;
    // Decoder already clears rd_write for x0
    assign result.wen     = issue.decoded.rd_write && !is_halt && !is_illegal;
    assign result.halt    = is_halt;
    assign result.illegal = is_illegal;

endmodule

// ==== hdl/rv_idu.sv ====
`include "rv_exec_consts.svh"

module rv_idu (
    input  logic [`RV_XLEN-1:0]      instr,
    output rv_exec_pkg::rv_decoded_t decoded
);

    // ------------------------------------------------------------
    // Field extraction
    // ------------------------------------------------------------

    rv_exec_pkg::rv_opcode_e opcode;
    rv_exec_pkg::rv_funct3_e funct3;
    logic [`RV_REG_AW-1:0]   rd;
    logic                    is_op_imm;
    logic                    arith_shift;

    assign opcode      = rv_exec_pkg::rv_opcode_e'(instr[6:0]);
    assign funct3      = rv_exec_pkg::rv_funct3_e'(instr[14:12]);
    assign rd          = instr[11:7];
    // Bit 30 set means srai, clear means srli
    assign arith_shift = instr[30];
    assign is_op_imm   = (opcode == rv_exec_pkg::OPC_OP_IMM);

    // ------------------------------------------------------------
    // Destination, immediate and operation select
    // ------------------------------------------------------------

    always_comb begin
        decoded.rd = rd;
        // I-type immediate, sign from bit 31
        decoded.imm = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
        // Only OP-IMM writes back, never to x0
        decoded.rd_write = is_op_imm && (rd != '0);
        // Anything not matched below stays illegal
        decoded.alu_op = rv_exec_pkg::ALU_ILLEGAL;
        case (opcode)
            rv_exec_pkg::OPC_OP_IMM: begin
                case (funct3)
                    rv_exec_pkg::F3_ADDI:  decoded.alu_op = rv_exec_pkg::ALU_ADD;
                    rv_exec_pkg::F3_SLLI:  decoded.alu_op = rv_exec_pkg::ALU_SLL;
                    rv_exec_pkg::F3_SLTI:  decoded.alu_op = rv_exec_pkg::ALU_SLT;
                    rv_exec_pkg::F3_SLTIU: decoded.alu_op = rv_exec_pkg::ALU_SLTU;
                    rv_exec_pkg::F3_XORI:  decoded.alu_op = rv_exec_pkg::ALU_XOR;
                    rv_exec_pkg::F3_SRLI_SRAI: begin
                        if (arith_shift) begin
                            decoded.alu_op = rv_exec_pkg::ALU_SRA;
                        end else begin
                            decoded.alu_op = rv_exec_pkg::ALU_SRL;
                        end
                    end
                    rv_exec_pkg::F3_ORI:   decoded.alu_op = rv_exec_pkg::ALU_OR;
                    rv_exec_pkg::F3_ANDI:  decoded.alu_op = rv_exec_pkg::ALU_AND;
                    default:               decoded.alu_op = rv_exec_pkg::ALU_ILLEGAL;
                endcase
            end
            rv_exec_pkg::OPC_SYSTEM: begin
                // Only the exact ebreak word, ecall and CSR ops are not supported
                if (instr == `RV_EBREAK_WORD) begin
                    decoded.alu_op = rv_exec_pkg::ALU_EBREAK;
                end
            end
            default: begin
                decoded.alu_op = rv_exec_pkg::ALU_ILLEGAL;
            end
        endcase
    end

endmodule

// ==== hdl/rv_regfile.sv ====
`include "rv_exec_consts.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`RV_REG_AW-1:0] rs1_addr,
    output logic [`RV_XLEN-1:0]   rs1_data,
    input  logic                  wr_en,
    input  logic [`RV_REG_AW-1:0] wr_addr,
    input  logic [`RV_XLEN-1:0]   wr_data
);

    // ------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------

    logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];
    logic                wr_ok;
    logic                bypass;

    // x0 is never written
    assign wr_ok = wr_en && (wr_addr != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            // All registers start at zero
            for (int i = 0; i < `RV_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // ------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------

    // Same-cycle write to the read index wins over the array
    assign bypass = wr_ok && (wr_addr == rs1_addr);

    always_comb begin
        if (rs1_addr == '0) begin
            // Hard zero
            rs1_data = '0;
        end else if (bypass) begin
            rs1_data = wr_data;
        end else begin
            rs1_data = regs[rs1_addr];
        end
    end

endmodule

// ==== rv_exec_top.f ====
+incdir+hdl
hdl/rv_exec_pkg.sv
hdl/rv_idu.sv
hdl/rv_regfile.sv
hdl/rv_exu.sv
hdl/rv_exec_top.sv
tb/rv_exec_top_tb.sv

// ==== tb/rv_exec_top_tb.sv ====
`include "rv_exec_consts.svh"

module rv_exec_top_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // ------------------------------------------------------------
    // Types and signals
    // ------------------------------------------------------------

    // One table row, instruction word and its expected commit
    typedef struct packed {
        logic [`RV_XLEN-1:0] word;
        logic [`RV_XLEN-1:0] value;
        logic                wen;
        logic                halt;
        logic                illegal;
    } vec_t;

    localparam int TIMEOUT_CYCLES = 40;
    localparam int NUM_RANDOM     = 40;

    logic                    clk;
    logic                    rst;
    logic                    instr_valid;
    logic                    instr_ready;
    logic [`RV_XLEN-1:0]     instr;
    logic                    commit_valid;
    logic                    commit_ready;
    rv_exec_pkg::rv_commit_t commit;
    logic                    halted;

    vec_t                tbl [$];
    // Reference register file, x0 never written
    logic [`RV_XLEN-1:0] ref_regs [`RV_NUM_REGS];
    integer              seed;
    int                  errors;
    int                  timeouts;
    int                  commits_seen;
    int                  stall_left;

    rv_exec_top DUT (
        .clk          (clk),
        .rst          (rst),
        .instr_valid  (instr_valid),
        .instr_ready  (instr_ready),
        .instr        (instr),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .commit       (commit),
        .halted       (halted)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ------------------------------------------------------------
    // Encoders and reference model
    // ------------------------------------------------------------

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input int imm);
        return {imm[11:0], rs1, f3, rd, 7'b0010011};
    endfunction

    // Shift form, bit 30 selects arithmetic right shift
    function automatic logic [31:0] enc_shift(input logic [2:0] f3, input logic arith,
                                              input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [4:0] shamt);
        return {1'b0, arith, 5'b0, shamt, rs1, f3, rd, 7'b0010011};
    endfunction

    // Expected commit for one word, updates the reference registers
    function automatic vec_t predict(input logic [31:0] word);
        vec_t        e;
        logic [31:0] a;
        logic [31:0] imm;
        logic [31:0] v;
        logic [4:0]  rd;
        logic [4:0]  sh;
        e      = '0;
        e.word = word;
        rd     = word[11:7];
        imm    = {{20{word[31]}}, word[31:20]};
        sh     = word[24:20];
        a      = ref_regs[word[19:15]];
        v      = '0;
        if (word[6:0] == 7'b0010011) begin
            case (word[14:12])
                3'd0: v = a + imm;
                3'd1: v = a << sh;
                3'd2: v = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
                3'd3: v = (a < imm) ? 32'd1 : 32'd0;
                3'd4: v = a ^ imm;
                3'd5: begin
                    // Bit 30 picks sign fill
                    if (word[30]) begin
                        v = $signed(a) >>> sh;
                    end else begin
                        v = a >> sh;
                    end
                end
                3'd6: v = a | imm;
                default: v = a & imm;
            endcase
            e.value = v;
            e.wen   = (rd != 5'd0);
            if (e.wen) begin
                ref_regs[rd] = v;
            end
        end else if (word == 32'h0010_0073) begin
            e.halt = 1'b1;
        end else begin
            e.illegal = 1'b1;
        end
        return e;
    endfunction

    task automatic add_entry(input logic [31:0] word);
        tbl.push_back(predict(word));
    endtask

    task automatic build_table();
        logic [31:0] r;
        for (int i = 0; i < `RV_NUM_REGS; i++) begin
            ref_regs[i] = '0;
        end
        // addi chain, each one reads the rd just before it
        add_entry(enc_i(3'd0, 5'd1, 5'd0, 5));
        add_entry(enc_i(3'd0, 5'd2, 5'd1, -3));
        add_entry(enc_i(3'd0, 5'd2, 5'd2, -2048));
        add_entry(enc_i(3'd0, 5'd3, 5'd2, 2047));
        // Write to x0 is dropped, then x0 reads zero
        add_entry(enc_i(3'd0, 5'd0, 5'd1, 7));
        add_entry(enc_i(3'd0, 5'd4, 5'd0, 0));
        // Shifts on negative values
        add_entry(enc_i(3'd0, 5'd5, 5'd0, -1));
        add_entry(enc_shift(3'd5, 1'b1, 5'd6, 5'd5, 5'd4));
        add_entry(enc_i(3'd0, 5'd7, 5'd0, -1024));
        add_entry(enc_shift(3'd5, 1'b1, 5'd8, 5'd7, 5'd3));
        add_entry(enc_shift(3'd5, 1'b0, 5'd9, 5'd7, 5'd3));
        add_entry(enc_shift(3'd1, 1'b0, 5'd10, 5'd7, 5'd20));
        // Compares and logic ops
        add_entry(enc_i(3'd2, 5'd11, 5'd7, -1000));
        add_entry(enc_i(3'd3, 5'd12, 5'd1, -1));
        add_entry(enc_i(3'd4, 5'd13, 5'd5, 12'h555));
        add_entry(enc_i(3'd6, 5'd14, 5'd7, 12'h0f0));
        add_entry(enc_i(3'd7, 5'd15, 5'd5, -16));
        // Register-register add and ecall are not decoded
        add_entry(32'h0000_00b3);
        add_entry(32'h0000_0073);
        add_entry(enc_i(3'd0, 5'd16, 5'd1, 0));
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = $random(seed);
            if (r[2:0] == 3'd1 || r[2:0] == 3'd5) begin
                add_entry(enc_shift(r[2:0], r[2] & r[25], r[7:3], r[12:8], r[17:13]));
            end else begin
                add_entry(enc_i(r[2:0], r[7:3], r[12:8], int'(r[24:13])));
            end
        end
        add_entry(32'h0010_0073);
    endtask

    // ------------------------------------------------------------
    // Back-pressure and protocol monitor
    // ------------------------------------------------------------

    always @(negedge clk) begin
        if (stall_left > 0) begin
            commit_ready = 1'b0;
            stall_left--;
        end else if (($random(seed) & 3) == 0) begin
            // Stall of one to three cycles
            commit_ready = 1'b0;
            stall_left   = $unsigned($random(seed)) % 3;
        end else begin
            commit_ready = 1'b1;
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (commit_valid && !commit_ready) begin
                assert (!instr_ready) else begin
                    $display("ERR %0t: instr_ready high while issue slot is stalled", $time);
                    errors++;
                end
            end
            if (halted) begin
                assert (!instr_ready) else begin
                    $display("ERR %0t: instr_ready high after halt", $time);
                    errors++;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Intake and commit processes
    // ------------------------------------------------------------

    task automatic feed_table();
        int waited;
        for (int i = 0; i < tbl.size(); i++) begin
            @(negedge clk);
            instr_valid = 1'b1;
            instr       = tbl[i].word;
            waited      = 0;
            // Hold the word until the DUT takes it
            do begin
                @(posedge clk);
                waited++;
            end while (!instr_ready && waited < TIMEOUT_CYCLES);
            if (!instr_ready) begin
                $display("Intake timed out on entry %0d after %0d cycles", i, waited);
                timeouts++;
                break;
            end
        end
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic compare_commit(input int idx, input vec_t exp);
        assert (commit.rd == exp.word[11:7]) else begin
            $display("ERR %0t: entry %0d rd %0d, expected %0d",
                     $time, idx, commit.rd, exp.word[11:7]);
            errors++;
        end
        assert (commit.value == exp.value) else begin
            $display("ERR %0t: entry %0d value %h, expected %h",
                     $time, idx, commit.value, exp.value);
            errors++;
        end
        assert ({commit.wen, commit.halt, commit.illegal} ==
                {exp.wen, exp.halt, exp.illegal}) else begin
            $display("ERR %0t: entry %0d flags wen/halt/illegal %b%b%b, expected %b%b%b",
                     $time, idx, commit.wen, commit.halt, commit.illegal,
                     exp.wen, exp.halt, exp.illegal);
            errors++;
        end
    endtask

    task automatic check_commits();
        int waited;
        for (int i = 0; i < tbl.size(); i++) begin
            waited = 0;
            do begin
                @(posedge clk);
                waited++;
            end while (!(commit_valid && commit_ready) && waited < TIMEOUT_CYCLES);
            if (!(commit_valid && commit_ready)) begin
                $display("No commit for entry %0d within %0d cycles", i, waited);
                timeouts++;
                break;
            end
            commits_seen++;
            compare_commit(i, tbl[i]);
        end
    endtask

    // After ebreak nothing is taken and nothing commits
    task automatic check_idle_after_halt();
        @(negedge clk);
        assert (halted) else begin
            $display("ERR %0t: halted low after ebreak commit", $time);
            errors++;
        end
        instr_valid = 1'b1;
        instr       = enc_i(3'd0, 5'd1, 5'd0, 1);
        for (int i = 0; i < TIMEOUT_CYCLES; i++) begin
            @(posedge clk);
            assert (!instr_ready && !commit_valid) else begin
                $display("ERR %0t: activity after halt, ready %b commit_valid %b",
                         $time, instr_ready, commit_valid);
                errors++;
            end
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------

    initial begin
        seed         = 32'hc458_58f4;
        errors       = 0;
        timeouts     = 0;
        commits_seen = 0;
        stall_left   = 0;
        rst          = 1'b1;
        instr_valid  = 1'b0;
        instr        = '0;
        commit_ready = 1'b1;
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        assert (!commit_valid && !halted && instr_ready) else begin
            $display("ERR %0t: wrong state after reset", $time);
            errors++;
        end
        fork
            feed_table();
            check_commits();
        join
        check_idle_after_halt();
        $display("Summary: entries %0d, commits %0d, errors %0d, timeouts %0d",
                 tbl.size(), commits_seen, errors, timeouts);
        if (errors == 0 && timeouts == 0 && commits_seen == tbl.size()) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
